// File: verilog.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/regfile.sv
verilog/fetch_unit.sv
verilog/instr_buffer.sv
verilog/issue_commit.sv
verilog/core_top.sv
tb/tb_imem.sv
tb/tb_core_top.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/isa_pkg.sv
      - verilog/regfile.sv
      - verilog/fetch_unit.sv
      - verilog/instr_buffer.sv
      - verilog/issue_commit.sv
      - verilog/core_top.sv
  - target: test
    files:
      - tb/tb_imem.sv
      - tb/tb_core_top.sv

// File: tb/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top
    import core_pkg::*;
    import isa_pkg::*;
();

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 16;
    localparam int PROG_LEN         = 24;
    localparam int SPIN_RUNS        = 3;   // Passes through the final self-jump
    localparam int CYCLES_PER_INSTR = 40;
    localparam int WATCHDOG_CYCLES  =
        RESET_CYCLES + (PROG_LEN + SPIN_RUNS) * CYCLES_PER_INSTR;
    localparam int IMEM_SEED        = 61314;

    logic                  clk;
    logic                  rst_n;
    logic                  mem_req;
    word_t                 mem_addr;
    logic                  mem_ack;
    logic [LINE_WIDTH-1:0] mem_data;
    commit_t               commit0;
    commit_t               commit1;
    word_t                 prog [PROG_LEN];

    word_t gold_regs [NUM_REGS];  // Reference architectural state
    word_t gold_pc;
    int    spin_count;
    int    commit_count;
    logic  done;

    core_top i_dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .mem_req_o  (mem_req),
        .mem_addr_o (mem_addr),
        .mem_ack_i  (mem_ack),
        .mem_data_i (mem_data),
        .commit0_o  (commit0),
        .commit1_o  (commit1)
    );

    tb_imem #(
        .PROG_LEN (PROG_LEN),
        .SEED     (IMEM_SEED)
    ) i_imem (
        .clk    (clk),
        .req_i  (mem_req),
        .addr_i (mem_addr),
        .ack_o  (mem_ack),
        .data_o (mem_data),
        .prog_i (prog)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic word_t encode_instr(input opcode_e op, input reg_addr_t rd,
                                           input reg_addr_t rj, input reg_addr_t rk,
                                           input logic [15:0] imm);
        word_t w;
        w = '0;
        w[OPC_MSB -: OPC_W] = op;
        w[RD_LSB +: 5]      = rd;
        w[RJ_LSB +: 5]      = rj;
        w[15:0]             = imm;
        w[RK_LSB +: 5]      = w[RK_LSB +: 5] | rk;  // rk shares bits with imm
        return w;
    endfunction

    task automatic load_program();
        prog[0]  = encode_instr(OP_LUI,  5'd1,  5'd0,  5'd0,  16'h1234);
        prog[1]  = encode_instr(OP_ADDI, 5'd1,  5'd1,  5'd0,  16'h0567);  // Depends on 0
        prog[2]  = encode_instr(OP_ADDI, 5'd2,  5'd0,  5'd0,  16'hFFFD);
        prog[3]  = encode_instr(OP_ADD,  5'd3,  5'd1,  5'd2,  16'h0000);
        prog[4]  = encode_instr(OP_ADDI, 5'd0,  5'd3,  5'd0,  16'h0007);  // r0 target
        prog[5]  = encode_instr(OP_ADD,  5'd4,  5'd0,  5'd3,  16'h0000);
        prog[6]  = encode_instr(OP_JUMP, 5'd0,  5'd0,  5'd0,  16'h0005);  // To 11 in mid-line
        prog[7]  = encode_instr(OP_ADDI, 5'd5,  5'd0,  5'd0,  16'h6666);  // Wrong path
        prog[8]  = encode_instr(OP_ADDI, 5'd5,  5'd0,  5'd0,  16'h7777);  // Wrong path
        prog[9]  = encode_instr(OP_ADD,  5'd5,  5'd4,  5'd2,  16'h0000);
        prog[10] = encode_instr(OP_JUMP, 5'd0,  5'd0,  5'd0,  16'h0004);  // To 14
        prog[11] = encode_instr(OP_ADDI, 5'd6,  5'd4,  5'd0,  16'h0001);
        prog[12] = encode_instr(OP_ADD,  5'd7,  5'd6,  5'd6,  16'h0000);
        prog[13] = encode_instr(OP_JUMP, 5'd0,  5'd0,  5'd0,  16'hFFFC);  // Back to 9
        prog[14] = encode_instr(OP_LUI,  5'd8,  5'd0,  5'd0,  16'hBEEF);
        prog[15] = encode_instr(OP_ADD,  5'd9,  5'd8,  5'd7,  16'h0000);
        prog[16] = encode_instr(OP_ADDI, 5'd0,  5'd0,  5'd0,  16'h0001);
        prog[17] = {4'hF, 5'd11, 23'd0};  // Unknown opcode
        prog[18] = encode_instr(OP_ADDI, 5'd12, 5'd0,  5'd0,  16'h0001);
        prog[19] = encode_instr(OP_ADDI, 5'd12, 5'd0,  5'd0,  16'h0002);  // Same rd in a pair
        prog[20] = encode_instr(OP_ADD,  5'd13, 5'd12, 5'd0,  16'h0000);
        prog[21] = INSTR_NOP;
        prog[22] = encode_instr(OP_ADD,  5'd10, 5'd9,  5'd5,  16'h0000);
        prog[23] = encode_instr(OP_JUMP, 5'd0,  5'd0,  5'd0,  16'h0000);  // Self-jump
    endtask

    // Architectural step of the next instruction in program order
    task automatic golden_step(output word_t pc, output logic wen,
                               output reg_addr_t waddr, output word_t wdata);
        word_t     instr;
        word_t     imm_s;
        word_t     next_pc;
        reg_addr_t rj;
        reg_addr_t rk;
        instr   = prog[gold_pc >> 2];
        rj      = instr[RJ_LSB +: 5];
        rk      = instr[RK_LSB +: 5];
        waddr   = instr[RD_LSB +: 5];
        imm_s   = {{16{instr[15]}}, instr[15:0]};
        pc      = gold_pc;
        wen     = 1'b0;
        wdata   = '0;
        next_pc = gold_pc + 32'd4;
        case (instr[OPC_MSB -: OPC_W])
            OP_ADDI: begin
                wdata = gold_regs[rj] + imm_s;
                wen   = 1'b1;
            end
            OP_ADD: begin
                wdata = gold_regs[rj] + gold_regs[rk];
                wen   = 1'b1;
            end
            OP_LUI: begin
                wdata = {instr[15:0], 16'h0000};
                wen   = 1'b1;
            end
            OP_JUMP: begin
                next_pc = gold_pc + imm_s * 4;
                if (next_pc == gold_pc)
                    spin_count++;
            end
            default: ;
        endcase
        if (waddr == '0)
            wen = 1'b0;
        if (wen)
            gold_regs[waddr] = wdata;
        gold_pc = next_pc;
    endtask

    task automatic check_commit(input commit_t c, input string port);
        word_t     exp_pc;
        logic      exp_wen;
        reg_addr_t exp_waddr;
        word_t     exp_wdata;
        golden_step(exp_pc, exp_wen, exp_waddr, exp_wdata);
        commit_count++;
        assert (c.pc == exp_pc) else fail_run($sformatf(
            "Mismatch %s.pc: got %h expected %h", port, c.pc, exp_pc));
        assert (c.wen == exp_wen) else fail_run($sformatf(
            "Mismatch %s.wen at pc %h: got %h expected %h", port, c.pc, c.wen, exp_wen));
        if (exp_wen) begin
            assert (c.waddr == exp_waddr) else fail_run($sformatf(
                "Mismatch %s.waddr at pc %h: got %h expected %h",
                port, c.pc, c.waddr, exp_waddr));
            assert (c.wdata == exp_wdata) else fail_run($sformatf(
                "Mismatch %s.wdata at pc %h: got %h expected %h",
                port, c.pc, c.wdata, exp_wdata));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Commit records change only at the rising edge
    always @(negedge clk) begin
        if (rst_n && !done) begin
            if (commit0.valid)
                check_commit(commit0, "commit0");
            if (commit1.valid)
                check_commit(commit1, "commit1");
            if (spin_count >= SPIN_RUNS)
                done = 1'b1;
        end
    end

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !$past(mem_ack))
        else fail_run("mem_req rose while mem_ack was still high");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else fail_run("mem_req dropped before mem_ack rose");

    a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req) |-> $past(mem_ack))
        else fail_run("mem_req fell without an ack");

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_addr[LINE_OFF_W-1:0] == '0)
        else fail_run($sformatf("Mismatch mem_addr[3:0]: got %h expected 0",
                                $sampled(mem_addr[LINE_OFF_W-1:0])));

    a_commit_pair: assert property (@(posedge clk) disable iff (!rst_n)
        commit1.valid |-> commit0.valid)
        else fail_run("commit1 valid without commit0 in the same cycle");

    initial begin
        rst_n        = 1'b0;
        done         = 1'b0;
        spin_count   = 0;
        commit_count = 0;
        gold_pc      = RESET_PC;
        for (int r = 0; r < NUM_REGS; r++)
            gold_regs[r] = '0;
        load_program();
        repeat (RESET_CYCLES) @(negedge clk);
        assert (!commit0.valid && !commit1.valid && !mem_req)
            else fail_run("Commit valid or mem_req high at the end of reset");
        rst_n = 1'b1;
        wait (done);
        @(negedge clk);
        $display("Program retired %0d instructions", commit_count);
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Timeout after %0d cycles before the final self-jump",
                           WATCHDOG_CYCLES));
    end

endmodule

// File: tb/tb_imem.sv
`timescale 1ns/1ps

module tb_imem import core_pkg::*; #(
    parameter int PROG_LEN  = 16,
    parameter int MAX_DELAY = 5,      // Cycles before ack rises
    parameter int SEED      = 61314
) (
    input  logic                  clk,
    input  logic                  req_i,
    input  word_t                 addr_i,
    output logic                  ack_o,
    output logic [LINE_WIDTH-1:0] data_o,
    input  word_t                 prog_i [PROG_LEN]
);

    int seed;

    function automatic word_t read_word(input word_t addr);
        if (addr < word_t'(PROG_LEN * 4))
            return prog_i[addr >> 2];
        return addr ^ 32'h5A5A_5A5A;  // Space past the program
    endfunction

    // Four-phase responder, changes only on the falling edge
    initial begin
        int delay;
        seed   = SEED;
        ack_o  = 1'b0;
        data_o = '0;
        forever begin
            @(negedge clk);
            if (req_i) begin
                delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
                repeat (delay) @(negedge clk);
                for (int i = 0; i < FETCH_WIDTH; i++)
                    data_o[i*XLEN +: XLEN] = read_word(addr_i + word_t'(i * 4));
                ack_o = 1'b1;
                do
                    @(negedge clk);
                while (req_i);
                delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
                repeat (delay) @(negedge clk);  // Slow release too
                ack_o = 1'b0;
            end
        end
    end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // Instruction memory, four-phase req/ack
    output logic                  mem_req_o,
    output word_t                 mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic [LINE_WIDTH-1:0] mem_data_i,

    // Debug commit ports
    output commit_t               commit0_o,
    output commit_t               commit1_o
);

    ib_entry_t              fetch_slots [FETCH_WIDTH];
    logic                   ib_space;
    ib_entry_t              ib_out [ISSUE_WIDTH];
    logic [1:0]             ib_pop;
    redirect_t              redirect;  // Jump flush and next PC

    reg_addr_t              rf_raddr [2*ISSUE_WIDTH];
    word_t                  rf_rdata [2*ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] rf_we;
    reg_addr_t              rf_waddr [ISSUE_WIDTH];
    word_t                  rf_wdata [ISSUE_WIDTH];

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ack_i     (mem_ack_i),
        .mem_data_i    (mem_data_i),
        .ib_space_i    (ib_space),
        .redirect_i    (redirect),
        .fetch_slots_o (fetch_slots)
    );

    instr_buffer u_instr_buffer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_slots_i (fetch_slots),
        .ib_space_o    (ib_space),
        .ib_out_o      (ib_out),
        .ib_pop_i      (ib_pop),
        .redirect_i    (redirect)
    );

    issue_commit u_issue_commit (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ib_out_i   (ib_out),
        .ib_pop_o   (ib_pop),
        .rf_raddr_o (rf_raddr),
        .rf_rdata_i (rf_rdata),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .redirect_o (redirect),
        .commit0_o  (commit0_o),
        .commit1_o  (commit1_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata)
    );

endmodule

// File: verilog/issue_commit.sv
`timescale 1ns/1ps

module issue_commit
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  ib_entry_t              ib_out_i [ISSUE_WIDTH],
    output logic [1:0]             ib_pop_o,

    output reg_addr_t              rf_raddr_o [2*ISSUE_WIDTH],
    input  word_t                  rf_rdata_i [2*ISSUE_WIDTH],
    output logic [ISSUE_WIDTH-1:0] rf_we_o,
    output reg_addr_t              rf_waddr_o [ISSUE_WIDTH],
    output word_t                  rf_wdata_o [ISSUE_WIDTH],

    output redirect_t              redirect_o,
    output commit_t                commit0_o,
    output commit_t                commit1_o
);

    opcode_e                opc      [ISSUE_WIDTH];
    reg_addr_t              rd       [ISSUE_WIDTH];
    reg_addr_t              rj       [ISSUE_WIDTH];
    reg_addr_t              rk       [ISSUE_WIDTH];
    word_t                  imm_sext [ISSUE_WIDTH];
    word_t                  result   [ISSUE_WIDTH];
    word_t                  target   [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] uses_rj;
    logic [ISSUE_WIDTH-1:0] uses_rk;
    logic [ISSUE_WIDTH-1:0] is_jump;
    logic [ISSUE_WIDTH-1:0] wen;
    logic [ISSUE_WIDTH-1:0] issue;
    logic                   dep_raw;

    // Decode and execute both head entries
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            opc[k] = opcode_e'(ib_out_i[k].instr[OPC_MSB -: OPC_W]);
            rd[k]  = ib_out_i[k].instr[RD_LSB +: $bits(reg_addr_t)];
            rj[k]  = ib_out_i[k].instr[RJ_LSB +: $bits(reg_addr_t)];
            rk[k]  = ib_out_i[k].instr[RK_LSB +: $bits(reg_addr_t)];
            imm_sext[k] = {{(XLEN-IMM_W){ib_out_i[k].instr[IMM_W-1]}},
                           ib_out_i[k].instr[IMM_W-1:0]};

            rf_raddr_o[2*k]   = rj[k];
            rf_raddr_o[2*k+1] = rk[k];

            target[k]  = ib_out_i[k].pc + (imm_sext[k] << JUMP_SHIFT);
            result[k]  = '0;
            uses_rj[k] = 1'b0;
            uses_rk[k] = 1'b0;
            is_jump[k] = 1'b0;
            wen[k]     = 1'b0;

            case (opc[k])
                OP_ADDI: begin
                    result[k]  = rf_rdata_i[2*k] + imm_sext[k];
                    uses_rj[k] = 1'b1;
                    wen[k]     = 1'b1;
                end
                OP_ADD: begin
                    result[k]  = rf_rdata_i[2*k] + rf_rdata_i[2*k+1];
                    uses_rj[k] = 1'b1;
                    uses_rk[k] = 1'b1;
                    wen[k]     = 1'b1;
                end
                OP_LUI: begin
                    result[k] = word_t'(ib_out_i[k].instr[IMM_W-1:0]) << LUI_SHIFT;
                    wen[k]    = 1'b1;
                end
                OP_JUMP: is_jump[k] = 1'b1;
                default: ;  // No-op, unknown encodings too
            endcase

            if (rd[k] == '0)
                wen[k] = 1'b0;  // r0 stays zero
        end
    end

    always_comb begin
        // Second entry may not read what the first writes
        dep_raw = wen[0] && ((uses_rj[1] && rj[1] == rd[0]) ||
                             (uses_rk[1] && rk[1] == rd[0]));

        issue[0] = ib_out_i[0].valid && !redirect_o.valid;  // Hold off wrong path
        issue[1] = issue[0] && ib_out_i[1].valid && !is_jump[0] && !dep_raw;
        ib_pop_o = {1'b0, issue[0]} + {1'b0, issue[1]};

        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rf_we_o[k]    = issue[k] && wen[k];
            rf_waddr_o[k] = rd[k];
            rf_wdata_o[k] = result[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit0_o  <= '0;
            commit1_o  <= '0;
            redirect_o <= '0;
        end else begin
            commit0_o <= '{valid: issue[0], pc: ib_out_i[0].pc, wen: rf_we_o[0],
                           waddr: rd[0], wdata: result[0]};
            commit1_o <= '{valid: issue[1], pc: ib_out_i[1].pc, wen: rf_we_o[1],
                           waddr: rd[1], wdata: result[1]};

            redirect_o.valid <= (issue[0] && is_jump[0]) || (issue[1] && is_jump[1]);
            redirect_o.pc    <= (issue[1] && is_jump[1]) ? target[1] : target[0];
        end
    end

endmodule

// File: verilog/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  ib_entry_t fetch_slots_i [FETCH_WIDTH],
    output logic      ib_space_o,

    output ib_entry_t ib_out_o [ISSUE_WIDTH],
    input  logic [1:0] ib_pop_i,

    input  redirect_t redirect_i
);

    typedef logic [IB_PTR_W-1:0] ptr_t;
    typedef logic [IB_PTR_W:0]   cnt_t;

    ib_entry_t buf_q [IB_DEPTH];
    ptr_t      head_q;
    ptr_t      tail_q;
    cnt_t      count_q;
    cnt_t      n_in;
    ptr_t      wr_idx [FETCH_WIDTH];

    // Room for a full line, from the registered count
    assign ib_space_o = (cnt_t'(IB_DEPTH) - count_q) >= cnt_t'(FETCH_WIDTH);

    // Compact valid slots in order behind the tail
    always_comb begin
        n_in = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            wr_idx[i] = tail_q + ptr_t'(n_in);
            if (fetch_slots_i[i].valid)
                n_in = n_in + cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (fetch_slots_i[i].valid)
                buf_q[wr_idx[i]] <= fetch_slots_i[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (redirect_i.valid) begin
            head_q  <= '0;  // Wrong-path entries dropped
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ptr_t'(ib_pop_i);
            tail_q  <= tail_q + ptr_t'(n_in);
            count_q <= count_q + n_in - cnt_t'(ib_pop_i);
        end
    end

    // Two oldest entries, valid taken from the count
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            ib_out_o[k]       = buf_q[head_q + ptr_t'(k)];
            ib_out_o[k].valid = count_q > cnt_t'(k);
        end
    end

    a_pop_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        cnt_t'(ib_pop_i) <= count_q);

    // Fetch must wait for space before it presents a line
    a_write_with_space: assert property (@(posedge clk) disable iff (!rst_n_i)
        (n_in != '0) |-> ib_space_o);

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,

    output logic                  mem_req_o,
    output word_t                 mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic [LINE_WIDTH-1:0] mem_data_i,

    input  logic                  ib_space_i,
    input  redirect_t             redirect_i,
    output ib_entry_t             fetch_slots_o [FETCH_WIDTH]
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        HOLD
    } fetch_state_e;

    fetch_state_e          state_q;
    word_t                 fetch_pc_q;   // Exact PC that may point mid-line
    word_t                 line_addr_q;  // Aligned address of the open request
    logic [LINE_WIDTH-1:0] line_q;
    logic                  discard_q;    // Redirect seen during a handshake
    logic                  line_taken;

    assign mem_req_o  = (state_q == REQ);
    assign mem_addr_o = line_addr_q;

    // Buffer takes the whole line in this cycle
    assign line_taken = (state_q == HOLD) && ib_space_i && !redirect_i.valid;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            fetch_slots_o[i].pc    = line_addr_q + word_t'(i * (XLEN / 8));
            fetch_slots_o[i].instr = line_q[i*XLEN +: XLEN];
            // Slots before a jump target are dropped
            fetch_slots_o[i].valid = line_taken &&
                                     (i >= int'(fetch_pc_q[2 +: SLOT_IDX_W]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            fetch_pc_q  <= RESET_PC;
            line_addr_q <= RESET_PC;
            discard_q   <= 1'b0;
        end else begin
            if (redirect_i.valid)
                fetch_pc_q <= redirect_i.pc;

            case (state_q)
                IDLE: begin
                    if (!redirect_i.valid && !mem_ack_i) begin
                        line_addr_q <= {fetch_pc_q[XLEN-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
                        state_q     <= REQ;
                    end
                end
                REQ: begin
                    if (redirect_i.valid)
                        discard_q <= 1'b1;
                    if (mem_ack_i)
                        state_q <= WAIT_ACK_LOW;  // Data captured below
                end
                WAIT_ACK_LOW: begin
                    if (!mem_ack_i) begin
                        discard_q <= 1'b0;
                        state_q   <= (discard_q || redirect_i.valid) ? IDLE : HOLD;
                    end else if (redirect_i.valid) begin
                        discard_q <= 1'b1;
                    end
                end
                HOLD: begin
                    if (redirect_i.valid) begin
                        state_q <= IDLE;
                    end else if (ib_space_i) begin
                        // Straight on to the next sequential line
                        line_addr_q <= line_addr_q + word_t'(LINE_BYTES);
                        fetch_pc_q  <= line_addr_q + word_t'(LINE_BYTES);
                        state_q     <= REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REQ && mem_ack_i)
            line_q <= mem_data_i;
    end

    // A new request waits until the previous ack has dropped
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mem_req_o) |-> !$past(mem_ack_i));

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  reg_addr_t              raddr_i [2*ISSUE_WIDTH],
    output word_t                  rdata_o [2*ISSUE_WIDTH],

    input  logic [ISSUE_WIDTH-1:0] we_i,
    input  reg_addr_t              waddr_i [ISSUE_WIDTH],
    input  word_t                  wdata_i [ISSUE_WIDTH]
);

    word_t regs [NUM_REGS];

    always_comb begin
        for (int p = 0; p < 2*ISSUE_WIDTH; p++)
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
    end

    // Later port is younger, so it lands last
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (we_i[k] && waddr_i[k] != '0)
                    regs[waddr_i[k]] <= wdata_i[k];
            end
        end
    end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

    // Instruction layout
    //   [31:28] opcode
    //   [27:23] rd
    //   [22:18] rj
    //   [17:13] rk, overlaps the immediate
    //   [15:0]  immediate
    localparam int OPC_W   = 4;
    localparam int OPC_MSB = 31;
    localparam int RD_LSB  = 23;
    localparam int RJ_LSB  = 18;
    localparam int RK_LSB  = 13;
    localparam int IMM_W   = 16;

    localparam int LUI_SHIFT  = 16;  // Upper half of the word
    localparam int JUMP_SHIFT = 2;   // Offset counts instructions

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_ADDI = 4'h1,
        OP_ADD  = 4'h2,
        OP_LUI  = 4'h3,
        OP_JUMP = 4'h4
    } opcode_e;

    // All fields zero
    localparam logic [31:0] INSTR_NOP = 32'h0000_0000;

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

    localparam int XLEN        = 32;
    localparam int LINE_WIDTH  = 128;
    localparam int FETCH_WIDTH = 4;    // Slots per cache line
    localparam int ISSUE_WIDTH = 2;
    localparam int IB_DEPTH    = 8;
    localparam int NUM_REGS    = 32;

    // Derived sizes
    localparam int LINE_BYTES = LINE_WIDTH / 8;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);
    localparam int SLOT_IDX_W = $clog2(FETCH_WIDTH);
    localparam int IB_PTR_W   = $clog2(IB_DEPTH);

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // One instruction slot, fetch to buffer to issue
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } ib_entry_t;

    // Retired instruction, shaped like the debug write-back port
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t pc;       // Target of the taken jump
    } redirect_t;

endpackage
